// ==== dcache.f ====
+incdir+src
src/dcache_pkg.sv
src/cache_array_if.sv
src/dcache_array.sv
src/dcache_ctrl.sv
src/dcache.sv
tests/dcache_mem_model.sv
tests/tb_dcache.sv

// ==== src/cache_array_if.sv ====
`include "dcache_defs.svh"

interface cache_array_if import dcache_pkg::*; ();

    // lookup address
    logic [`DC_IDX_W-1:0] lk_idx;
    logic [`DC_TAG_W-1:0] lk_tag;

    // write commands and their operands
    logic  fill_en;
    logic  store_en;
    logic  clean_en;
    logic  inval_en;
    logic  touch_en;
    logic  cmd_way;
    logic  cmd_word;
    word_t cmd_data;

    // lookup results for lk_idx
    logic                 hit;
    logic                 hit_way;
    logic                 victim_way;
    logic                 victim_dirty;
    logic [`DC_TAG_W-1:0] victim_tag;
    word_t                rd_word0;
    word_t                rd_word1;
    logic                 set_dirty_any;

    modport ctrl (
        output lk_idx, lk_tag, fill_en, store_en, clean_en, inval_en, touch_en,
        output cmd_way, cmd_word, cmd_data,
        input  hit, hit_way, victim_way, victim_dirty, victim_tag,
        input  rd_word0, rd_word1, set_dirty_any
    );

    modport array (
        input  lk_idx, lk_tag, fill_en, store_en, clean_en, inval_en, touch_en,
        input  cmd_way, cmd_word, cmd_data,
        output hit, hit_way, victim_way, victim_dirty, victim_tag,
        output rd_word0, rd_word1, set_dirty_any
    );

endinterface

// ==== src/dcache.sv ====
module dcache import dcache_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  halt,
    input  logic  dmemREN,
    input  logic  dmemWEN,
    input  word_t dmemaddr,
    input  word_t dmemstore,
    input  word_t dload,
    input  logic  dwait,
    output logic  dhit,
    output word_t dmemload,
    output logic  flushed,
    output logic  dREN,
    output logic  dWEN,
    output word_t daddr,
    output word_t dstore
);

    dc_addr_u bus_addr;

    cache_array_if arr_if ();

    dcache_ctrl u_ctrl (
        .CLK       (CLK),
        .nRST      (nRST),
        .halt      (halt),
        .dmemREN   (dmemREN),
        .dmemWEN   (dmemWEN),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .dload     (dload),
        .dwait     (dwait),
        .dhit      (dhit),
        .dmemload  (dmemload),
        .flushed   (flushed),
        .dREN      (dREN),
        .dWEN      (dWEN),
        .daddr     (bus_addr),
        .dstore    (dstore),
        .arr       (arr_if.ctrl)
    );

    dcache_array u_array (
        .CLK  (CLK),
        .nRST (nRST),
        .arr  (arr_if.array)
    );

    // raw view of the registered bus address
    assign daddr = bus_addr.raw;

endmodule

// ==== src/dcache_array.sv ====
`include "dcache_defs.svh"

module dcache_array import dcache_pkg::*; (
    input logic         CLK,
    input logic         nRST,
    cache_array_if.array arr
);

    // control bits, indexed [way][set]
    logic [1:0][`DC_SETS-1:0] valid_q;
    logic [1:0][`DC_SETS-1:0] dirty_q;

    // lru_q holds the way to replace next
    logic [`DC_SETS-1:0] lru_q;

    // payload
    logic [`DC_TAG_W-1:0] tag_q  [2][`DC_SETS];
    word_t                data_q [2][`DC_SETS][`DC_BLK_WORDS];

    logic [`DC_IDX_W-1:0] idx;
    logic [1:0]           way_hit;
    logic                 victim;
    logic                 sel_way;

    assign idx = arr.lk_idx;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][idx] && (tag_q[w][idx] == arr.lk_tag);
        end
    end

    // tags are unique within a set, so at most one way hits
    assign arr.hit     = |way_hit;
    assign arr.hit_way = way_hit[1];

    assign victim           = lru_q[idx];
    assign arr.victim_way   = victim;
    assign arr.victim_dirty = dirty_q[victim][idx];
    assign arr.victim_tag   = tag_q[victim][idx];

    assign arr.set_dirty_any = dirty_q[0][idx] | dirty_q[1][idx];

    // words of the hit way, or of the victim on a miss
    assign sel_way      = arr.hit ? arr.hit_way : victim;
    assign arr.rd_word0 = data_q[sel_way][idx][0];
    assign arr.rd_word1 = data_q[sel_way][idx][1];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            // line becomes valid once its second word is in
            if (arr.fill_en) begin
                valid_q[arr.cmd_way][idx] <= arr.cmd_word;
                dirty_q[arr.cmd_way][idx] <= 1'b0;
            end
            if (arr.store_en) begin
                valid_q[arr.cmd_way][idx] <= 1'b1;
                dirty_q[arr.cmd_way][idx] <= 1'b1;
            end
            if (arr.clean_en) begin
                dirty_q[arr.cmd_way][idx] <= 1'b0;
            end
            if (arr.inval_en) begin
                valid_q[arr.cmd_way][idx] <= 1'b0;
                dirty_q[arr.cmd_way][idx] <= 1'b0;
            end
            // touched way is most recent, the other one goes next
            if (arr.touch_en) begin
                lru_q[idx] <= ~arr.cmd_way;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (arr.fill_en || arr.store_en) begin
            data_q[arr.cmd_way][idx][arr.cmd_word] <= arr.cmd_data;
        end
        if (arr.fill_en) begin
            tag_q[arr.cmd_way][idx] <= arr.lk_tag;
        end
    end

    // the controller fills only outside IDLE and stores only in IDLE
    assert property (@(posedge CLK) disable iff (!nRST)
        !(arr.fill_en && arr.store_en))
        else $error("fill and store commands in the same cycle");

endmodule

// ==== src/dcache_ctrl.sv ====
`include "dcache_defs.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        halt,
    input  logic        dmemREN,
    input  logic        dmemWEN,
    input  word_t       dmemaddr,
    input  word_t       dmemstore,
    input  word_t       dload,
    input  logic        dwait,
    output logic        dhit,
    output word_t       dmemload,
    output logic        flushed,
    output logic        dREN,
    output logic        dWEN,
    output dc_addr_u    daddr,
    output word_t       dstore,
    cache_array_if.ctrl arr
);

    dc_state_t state;
    dc_state_t next_state;

    dc_addr_u req;
    dc_addr_u daddr_n;

    // one wider than the index so it can reach DC_SETS
    logic [`DC_IDX_W:0] fl_set;
    logic [`DC_IDX_W:0] fl_set_n;

    logic flush_mode;
    logic req_any;

    assign req.raw    = dmemaddr;
    assign req_any    = dmemREN | dmemWEN;
    assign flush_mode = state inside {FLUSH_SCAN, FLUSH_WB1, FLUSH_WB2, DONE};

    // while flushing, look up the victim's own tag so the read words are its data
    assign arr.lk_idx = flush_mode ? fl_set[`DC_IDX_W-1:0] : req.f.idx;
    assign arr.lk_tag = flush_mode ? arr.victim_tag : req.f.tag;

    // commands act on the hit way in IDLE, on the victim otherwise
    assign arr.cmd_way  = (state == IDLE) ? arr.hit_way : arr.victim_way;
    assign arr.cmd_word = (state == IDLE) ? req.f.blkoff : daddr.f.blkoff;
    assign arr.cmd_data = (state == IDLE) ? dmemstore : dload;

    assign dmemload = req.f.blkoff ? arr.rd_word1 : arr.rd_word0;
    assign dstore   = daddr.f.blkoff ? arr.rd_word1 : arr.rd_word0;
    assign flushed  = (state == DONE);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state  <= IDLE;
            daddr  <= '0;
            fl_set <= '0;
        end else begin
            state  <= next_state;
            daddr  <= daddr_n;
            fl_set <= fl_set_n;
        end
    end

    always_comb begin
        next_state   = state;
        daddr_n      = daddr;
        fl_set_n     = fl_set;
        dhit         = 1'b0;
        dREN         = 1'b0;
        dWEN         = 1'b0;
        arr.fill_en  = 1'b0;
        arr.store_en = 1'b0;
        arr.clean_en = 1'b0;
        arr.inval_en = 1'b0;
        arr.touch_en = 1'b0;

        case (state)
            IDLE: begin
                if (halt) begin
                    fl_set_n   = '0;
                    next_state = FLUSH_SCAN;
                end else if (req_any && arr.hit) begin
                    dhit         = 1'b1;
                    arr.touch_en = 1'b1;
                    arr.store_en = dmemWEN;
                end else if (req_any) begin
                    daddr_n.f.idx    = req.f.idx;
                    daddr_n.f.blkoff = 1'b0;
                    daddr_n.f.bytoff = 2'b00;
                    // dirty victim goes back to memory before the fill
                    if (arr.victim_dirty) begin
                        daddr_n.f.tag = arr.victim_tag;
                        next_state    = WB1;
                    end else begin
                        daddr_n.f.tag = req.f.tag;
                        next_state    = AL1;
                    end
                end
            end

            WB1: begin
                dWEN = 1'b1;
                if (!dwait) begin
                    daddr_n.f.blkoff = 1'b1;
                    next_state       = WB2;
                end
            end

            WB2: begin
                dWEN = 1'b1;
                if (!dwait) begin
                    arr.inval_en     = 1'b1;
                    daddr_n.f.tag    = req.f.tag;
                    daddr_n.f.blkoff = 1'b0;
                    next_state       = AL1;
                end
            end

            AL1: begin
                dREN = 1'b1;
                if (!dwait) begin
                    arr.fill_en      = 1'b1;
                    daddr_n.f.blkoff = 1'b1;
                    next_state       = AL2;
                end
            end

            // back in IDLE the held request hits
            AL2: begin
                dREN = 1'b1;
                if (!dwait) begin
                    arr.fill_en = 1'b1;
                    next_state  = IDLE;
                end
            end

            FLUSH_SCAN: begin
                if (fl_set == `DC_SETS) begin
                    next_state = DONE;
                end else if (!arr.set_dirty_any) begin
                    fl_set_n = fl_set + 1'b1;
                end else if (arr.victim_dirty) begin
                    daddr_n.f.tag    = arr.victim_tag;
                    daddr_n.f.idx    = fl_set[`DC_IDX_W-1:0];
                    daddr_n.f.blkoff = 1'b0;
                    daddr_n.f.bytoff = 2'b00;
                    next_state       = FLUSH_WB1;
                end else begin
                    // only the other way is dirty, turn the LRU towards it
                    arr.touch_en = 1'b1;
                end
            end

            FLUSH_WB1: begin
                dWEN = 1'b1;
                if (!dwait) begin
                    daddr_n.f.blkoff = 1'b1;
                    next_state       = FLUSH_WB2;
                end
            end

            FLUSH_WB2: begin
                dWEN = 1'b1;
                if (!dwait) begin
                    arr.clean_en = 1'b1;
                    next_state   = FLUSH_SCAN;
                end
            end

            DONE: begin
                next_state = DONE;
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

    assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN))
        else $error("dREN and dWEN high together");

    // bus transfers are whole words
    assert property (@(posedge CLK) disable iff (!nRST)
        (dREN || dWEN) |-> (daddr.f.bytoff == 2'b00))
        else $error("daddr not word aligned: %h", daddr.raw);

endmodule

// ==== src/dcache_defs.svh ====
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// data word and bus address width
`define DC_WORD_W 32

// two ways of 8 sets
`define DC_SETS 8
`define DC_IDX_W 3

// tag is what is left above index, block and byte offset
`define DC_TAG_W 26

// words per block
`define DC_BLK_WORDS 2

`endif

// ==== src/dcache_pkg.sv ====
`include "dcache_defs.svh"

package dcache_pkg;

    typedef logic [`DC_WORD_W-1:0] word_t;

    // address split: tag, set index, word in block, byte in word
    typedef struct packed {
        logic [`DC_TAG_W-1:0] tag;
        logic [`DC_IDX_W-1:0] idx;
        logic                 blkoff;
        logic [1:0]           bytoff;
    } dc_addr_t;

    typedef union packed {
        word_t    raw;
        dc_addr_t f;
    } dc_addr_u;

    typedef enum logic [3:0] {
        IDLE,
        WB1,
        WB2,
        AL1,
        AL2,
        FLUSH_SCAN,
        FLUSH_WB1,
        FLUSH_WB2,
        DONE
    } dc_state_t;

endpackage

// ==== tests/dcache_mem_model.sv ====
module dcache_mem_model (
    input  logic        CLK,
    input  logic        dREN,
    input  logic        dWEN,
    input  logic [31:0] daddr,
    input  logic [31:0] dstore,
    output logic [31:0] dload,
    output logic        dwait
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WORDS = 128;

    logic [31:0] words [WORDS];
    integer      seed;

    // every byte depends on the whole word index
    function automatic logic [31:0] pattern(int unsigned i);
        return {i[7:0] ^ 8'h5a, ~i[7:0], i[7:0] + 8'h31, i[7:0]};
    endfunction

    initial begin
        seed  = 64;
        dwait = 1'b0;
        for (int i = 0; i < WORDS; i++) begin
            words[i] = pattern(i);
        end
    end

    // stall on about half of the cycles
    always @(negedge CLK) begin
        dwait <= ($random(seed) % 2) != 0;
    end

    assign dload = words[daddr[8:2]];

    // a transfer completes when dwait is low
    always @(posedge CLK) begin
        if (dWEN && !dwait) begin
            words[daddr[8:2]] <= dstore;
        end
    end

endmodule

// ==== tests/tb_dcache.sv ====
module tb_dcache;
    timeunit 1ns;
    timeprecision 100ps;

    // 200 accesses of up to four stalled bus words each, plus the flush
    localparam int MAX_CYCLES = 8000;
    localparam int N_ACCESS   = 200;
    localparam int WORDS      = 128;

    logic        CLK;
    logic        nRST;
    logic        halt;
    logic        dmemREN;
    logic        dmemWEN;
    logic [31:0] dmemaddr;
    logic [31:0] dmemstore;
    logic [31:0] dload;
    logic        dwait;
    logic        dhit;
    logic [31:0] dmemload;
    logic        flushed;
    logic        dREN;
    logic        dWEN;
    logic [31:0] daddr;
    logic [31:0] dstore;

    logic [31:0] shadow [WORDS];
    logic [31:0] exp_load;
    logic [31:0] exp_store;
    logic        req_seen = 1'b0;
    logic        repeat_req = 1'b0;
    logic        hit_taken = 1'b0;
    int          cycles = 0;
    int          mem_writes = 0;
    integer      seed;

    dcache UUT (.*);

    dcache_mem_model mem_model (.*);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "run stopped at cycle %0d", cycles);
    endtask

    function automatic logic [31:0] initial_word(int unsigned i);
        return {i[7:0] ^ 8'h5a, ~i[7:0], i[7:0] + 8'h31, i[7:0]};
    endfunction

    function automatic logic [31:0] block_addr(int tag, int set, int blk);
        return (tag << 6) | (set << 3) | (blk << 2);
    endfunction

    function automatic int rand_below(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    assign exp_load  = shadow[dmemaddr[8:2]];
    assign exp_store = shadow[daddr[8:2]];

    // shadow memory follows the stores that the cache accepts
    always @(posedge CLK) begin
        hit_taken <= dhit;
        if (dhit && dmemWEN) begin
            shadow[dmemaddr[8:2]] <= dmemstore;
        end
        if (dWEN && !dwait) begin
            mem_writes <= mem_writes + 1;
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            abort_run();
        end
    end

    assert property (@(posedge CLK) !req_seen |-> !(dREN || dWEN || dhit || flushed))
        else begin
            $display("bus request, dhit or flushed high before the first request");
            abort_run();
        end

    assert property (@(posedge CLK) disable iff (!nRST)
        (dhit && dmemREN) |-> (dmemload == exp_load))
        else begin
            $display("** Error: dmemload = %h, expected %h at dmemaddr %h",
                $sampled(dmemload), $sampled(exp_load), $sampled(dmemaddr));
            abort_run();
        end

    assert property (@(posedge CLK) disable iff (!nRST)
        repeat_req |-> (dhit && !dREN && !dWEN))
        else begin
            $display("repeated request to the same block was not hit at once");
            abort_run();
        end

    assert property (@(posedge CLK) disable iff (!nRST)
        (dWEN && !dwait) |-> (dstore == exp_store))
        else begin
            $display("** Error: dstore = %h, expected %h at daddr %h",
                $sampled(dstore), $sampled(exp_store), $sampled(daddr));
            abort_run();
        end

    assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
        else begin
            $display("flushed fell after it was raised");
            abort_run();
        end

    assert property (@(posedge CLK) disable iff (!nRST) flushed |-> !(dREN || dWEN))
        else begin
            $display("bus request after flushed was raised");
            abort_run();
        end

    assert property (@(posedge CLK) !(dREN && dWEN))
        else begin
            $display("dREN and dWEN high in the same cycle");
            abort_run();
        end

    assert property (@(posedge CLK) (dREN || dWEN) |-> (daddr[1:0] == 2'b00))
        else begin
            $display("** Error: daddr = %h, not word aligned", $sampled(daddr));
            abort_run();
        end

    // a stalled transfer keeps request, address and data
    assert property (@(posedge CLK) disable iff (!nRST)
        ((dREN || dWEN) && dwait) |=>
        ($stable(daddr) && $stable(dstore) && $stable(dREN) && $stable(dWEN)))
        else begin
            $display("bus request, address or store data changed while dwait was high");
            abort_run();
        end

    // called on a falling edge, returns on the falling edge after the accepted dhit
    task automatic access(input logic we, input logic [31:0] addr,
                          input logic [31:0] data, input logic again);
        dmemREN    = !we;
        dmemWEN    = we;
        dmemaddr   = addr;
        dmemstore  = data;
        repeat_req = again;
        req_seen   = 1'b1;
        do begin
            @(negedge CLK);
        end while (!hit_taken);
        repeat_req = 1'b0;
    endtask

    initial begin
        logic [31:0] addr;
        int          tag;
        int          set;
        int          blk;
        logic        we;

        nRST      = 1'b0;
        halt      = 1'b0;
        dmemREN   = 1'b0;
        dmemWEN   = 1'b0;
        dmemaddr  = '0;
        dmemstore = '0;
        seed      = 64;
        for (int i = 0; i < WORDS; i++) begin
            shadow[i] = initial_word(i);
        end
        repeat (8) @(negedge CLK);
        nRST = 1'b1;
        repeat (2) @(negedge CLK);

        // three dirty tags in set 1, the third evicts the first
        for (int t = 0; t < 3; t++) begin
            access(1'b1, block_addr(t, 1, 0), 32'hd1e7_0000 + t, 1'b0);
        end
        assert (mem_writes >= 2)
            else begin
                $display("dirty victim was not written back on eviction");
                abort_run();
            end
        for (int b = 0; b < 2; b++) begin
            addr = block_addr(0, 1, b);
            assert (mem_model.words[addr[8:2]] == shadow[addr[8:2]])
                else begin
                    $display("** Error: mem[%h] = %h, expected %h", addr,
                        mem_model.words[addr[8:2]], shadow[addr[8:2]]);
                    abort_run();
                end
        end

        // five tags in each of sets 1 and 6
        for (int n = 0; n < N_ACCESS; n++) begin
            set = (rand_below(2) == 1) ? 6 : 1;
            tag = rand_below(5);
            blk = rand_below(2);
            we  = (rand_below(2) == 1);
            access(we, block_addr(tag, set, blk), $random(seed), 1'b0);
            if (rand_below(4) == 0) begin
                access(!we, block_addr(tag, set, 1 - blk), $random(seed), 1'b1);
            end
        end

        dmemREN = 1'b0;
        dmemWEN = 1'b0;
        halt    = 1'b1;
        while (!flushed) begin
            @(negedge CLK);
        end
        for (int i = 0; i < WORDS; i++) begin
            assert (mem_model.words[i] == shadow[i])
                else begin
                    $display("** Error: mem[%h] = %h, expected %h", i,
                        mem_model.words[i], shadow[i]);
                    abort_run();
                end
        end

        // flushed holds and the bus stays quiet
        repeat (20) @(negedge CLK);
        $display("all tests passed");
        $finish;
    end

endmodule
